/* Bender.yml */
package:
  name: dcpl_static

sources:
  - files:
      - hw/dcpl_pkg.sv
      - hw/axis_if.sv
      - hw/dma_req_if.sv
      - hw/dcpl_ctrl.sv
      - hw/axis_dcpl_slice.sv
      - hw/wback_dma.sv
      - hw/dcpl_static.sv
  - target: test
    files:
      - bench/tb_dcpl_static.sv

/* bench/tb_dcpl_static.sv */
`timescale 1ns/1ps

module tb_dcpl_static;

  localparam int NS      = dcpl_pkg::N_SCHAN;
  localparam int DW      = dcpl_pkg::AXI_DATA_BITS;
  localparam int IW      = dcpl_pkg::IRQ_BITS;
  localparam int TIMEOUT = 400;  // cycles per wait.

  typedef logic [DW+DW/8:0] beat_t;  // data, keep, last.
  typedef logic [dcpl_pkg::DMA_ADDR_BITS+dcpl_pkg::DMA_LEN_BITS-1:0] req_t;  // addr, len.

  logic                                  aclk;
  logic                                  aresetn;
  logic                                  s_decouple;
  logic [IW-1:0]                         s_usr_irq;
  logic [IW-1:0]                         m_usr_irq;
  logic [NS-1:0][DW-1:0]                 s_axis_dyn_out_tdata;
  logic [NS-1:0][DW/8-1:0]               s_axis_dyn_out_tkeep;
  logic [NS-1:0]                         s_axis_dyn_out_tlast;
  logic [NS-1:0]                         s_axis_dyn_out_tvalid;
  logic [NS-1:0]                         s_axis_dyn_out_tready;
  logic [NS-1:0][DW-1:0]                 m_axis_dyn_in_tdata;
  logic [NS-1:0][DW/8-1:0]               m_axis_dyn_in_tkeep;
  logic [NS-1:0]                         m_axis_dyn_in_tlast;
  logic [NS-1:0]                         m_axis_dyn_in_tvalid;
  logic [NS-1:0]                         m_axis_dyn_in_tready;
  logic [NS-1:0][DW-1:0]                 s_axis_dyn_in_tdata;
  logic [NS-1:0][DW/8-1:0]               s_axis_dyn_in_tkeep;
  logic [NS-1:0]                         s_axis_dyn_in_tlast;
  logic [NS-1:0]                         s_axis_dyn_in_tvalid;
  logic [NS-1:0]                         s_axis_dyn_in_tready;
  logic [NS-1:0][DW-1:0]                 m_axis_dyn_out_tdata;
  logic [NS-1:0][DW/8-1:0]               m_axis_dyn_out_tkeep;
  logic [NS-1:0]                         m_axis_dyn_out_tlast;
  logic [NS-1:0]                         m_axis_dyn_out_tvalid;
  logic [NS-1:0]                         m_axis_dyn_out_tready;
  logic                                  s_wback_valid;
  logic                                  s_wback_ready;
  dcpl_pkg::wback_t                      s_wback_data;
  logic [DW-1:0]                         m_axis_wb_tdata;
  logic [DW/8-1:0]                       m_axis_wb_tkeep;
  logic                                  m_axis_wb_tlast;
  logic                                  m_axis_wb_tvalid;
  logic                                  m_axis_wb_tready;
  logic [dcpl_pkg::DMA_ADDR_BITS-1:0]    m_dma_wb_addr;
  logic [dcpl_pkg::DMA_LEN_BITS-1:0]     m_dma_wb_len;
  logic                                  m_dma_wb_valid;
  logic                                  m_dma_wb_ready;

  beat_t q_dout [NS][$];  // expected at m_axis_dyn_out.
  beat_t q_din  [NS][$];  // expected at m_axis_dyn_in.
  beat_t q_wb   [$];      // expected at m_axis_wb.
  req_t  q_req  [$];      // expected dma requests.
  int    errors;
  int    timeouts;
  int    checks;
  int    n_tests;
  int    err_mark;        // error total at test start.

  dcpl_static dut0 (.*);

  initial begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;  // 40 ns period.
  end

  // stream channels pass beats unchanged.
  function automatic beat_t ref_stream(input beat_t b);
    return b;
  endfunction

  function automatic req_t ref_wb_req(input dcpl_pkg::wback_t r);
    return {r.paddr, dcpl_pkg::DMA_LEN_BITS'(dcpl_pkg::WB_LEN)};  // fixed 4 byte write.
  endfunction

  function automatic beat_t ref_wb_beat(input dcpl_pkg::wback_t r);
    return {{(DW - dcpl_pkg::WB_DATA_BITS){1'b0}}, r.value, 8'h0f, 1'b1};  // low lanes only.
  endfunction

  function automatic logic [IW-1:0] ref_irq(input logic [IW-1:0] irq, input logic dcpl);
    return dcpl ? '0 : irq;  // masked while cut.
  endfunction

  function automatic int pending();
    int n;
    n = q_wb.size() + q_req.size();
    for (int c = 0; c < NS; c++) begin
      n += q_dout[c].size() + q_din[c].size();
    end
    return n;
  endfunction

  task automatic check_value(input string sig, input logic [127:0] got,
                             input logic [127:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED %s got %h exp %h", sig, got, exp);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: %s gave up after %0d cycles", what, TIMEOUT);
    timeouts++;
  endtask

  task automatic end_test(input string name);
    n_tests++;
    $display("test %0d %s: %s", n_tests, name,
             (errors + timeouts == err_mark) ? "ok" : "errors seen");
    err_mark = errors + timeouts;
  endtask

  task automatic drop_valid(input bit to_user, input int ch);
    if (to_user) begin
      s_axis_dyn_in_tvalid[ch] = 1'b0;
    end else begin
      s_axis_dyn_out_tvalid[ch] = 1'b0;
    end
  endtask

  // present one beat, hold until taken.
  task automatic send_beat(input bit to_user, input int ch, input beat_t b);
    int   n;
    logic rdy;
    @(negedge aclk);
    if (to_user) begin
      {s_axis_dyn_in_tdata[ch], s_axis_dyn_in_tkeep[ch], s_axis_dyn_in_tlast[ch]} = b;
      s_axis_dyn_in_tvalid[ch] = 1'b1;
    end else begin
      {s_axis_dyn_out_tdata[ch], s_axis_dyn_out_tkeep[ch], s_axis_dyn_out_tlast[ch]} = b;
      s_axis_dyn_out_tvalid[ch] = 1'b1;
    end
    n   = 0;
    rdy = 1'b0;
    while (!rdy && n < TIMEOUT) begin
      @(posedge aclk);
      rdy = to_user ? s_axis_dyn_in_tready[ch] : s_axis_dyn_out_tready[ch];
      n++;
    end
    if (!rdy) begin
      report_timeout($sformatf("stream source %0d on channel %0d", to_user, ch));
    end else if (to_user) begin
      q_din[ch].push_back(ref_stream(b));
    end else begin
      q_dout[ch].push_back(ref_stream(b));
    end
  endtask

  task automatic stream_burst(input bit to_user, input int ch, input int n);
    beat_t b;
    for (int i = 0; i < n; i++) begin
      if ($urandom % 4 == 0) begin
        @(negedge aclk);
        drop_valid(to_user, ch);  // idle gap.
      end
      b = {$urandom, $urandom, 8'($urandom), 1'($urandom)};
      send_beat(to_user, ch, b);
    end
    @(negedge aclk);
    drop_valid(to_user, ch);
  endtask

  task automatic wait_wb_accept(input dcpl_pkg::wback_t r);
    int   n;
    logic ok;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < TIMEOUT) begin
      @(posedge aclk);
      ok = s_wback_ready;  // valid already high.
      n++;
    end
    if (!ok) begin
      report_timeout("writeback source");
    end else begin
      q_req.push_back(ref_wb_req(r));
      q_wb.push_back(ref_wb_beat(r));
    end
  endtask

  task automatic wb_burst(input int n);
    dcpl_pkg::wback_t r;
    for (int i = 0; i < n; i++) begin
      if ($urandom % 3 == 0) begin
        @(negedge aclk);
        s_wback_valid = 1'b0;
      end
      r = {$urandom, $urandom, $urandom};
      @(negedge aclk);
      s_wback_data  = r;
      s_wback_valid = 1'b1;
      wait_wb_accept(r);
    end
    @(negedge aclk);
    s_wback_valid = 1'b0;
  endtask

  task automatic wait_idle(input string what);
    int n;
    n = 0;
    while (pending() != 0 && n < TIMEOUT) begin
      @(negedge aclk);  // pops from posedge are settled.
      n++;
    end
    if (pending() != 0) begin
      report_timeout($sformatf("%s with %0d beats still missing", what, pending()));
    end
  endtask

  // every gate must hold while cut.
  task automatic watch_cut(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge aclk);
      check_value("s_axis_dyn_out_tready", 128'(s_axis_dyn_out_tready), 128'(0));
      check_value("m_axis_dyn_in_tvalid", 128'(m_axis_dyn_in_tvalid), 128'(0));
      check_value("s_wback_ready", 128'(s_wback_ready), 128'(0));
      check_value("m_dma_wb_valid", 128'(m_dma_wb_valid), 128'(0));
      check_value("m_axis_wb_tvalid", 128'(m_axis_wb_tvalid), 128'(0));
    end
  endtask

  task automatic drive_stalls();
    forever begin
      @(negedge aclk);
      m_axis_dyn_out_tready = NS'($urandom | $urandom);  // ready about 3 of 4.
      m_axis_dyn_in_tready  = NS'($urandom | $urandom);
      m_axis_wb_tready      = ($urandom % 4 != 0);
      m_dma_wb_ready        = ($urandom % 3 != 0);
    end
  endtask

  task automatic drive_irq();
    forever begin
      @(negedge aclk);
      if (aresetn) begin
        s_usr_irq = IW'($urandom);
      end
    end
  endtask

  task automatic compare_outputs();
    beat_t         got;
    logic [IW-1:0] irq_hist [3];  // index k is k+1 cycles old.
    logic          dec_hist [5];
    forever begin
      @(posedge aclk);
      if (aresetn) begin
        check_value("m_usr_irq", 128'(m_usr_irq), 128'(ref_irq(irq_hist[2], dec_hist[4])));
        for (int c = 0; c < NS; c++) begin
          if (m_axis_dyn_out_tvalid[c] && m_axis_dyn_out_tready[c]) begin
            got = {m_axis_dyn_out_tdata[c], m_axis_dyn_out_tkeep[c], m_axis_dyn_out_tlast[c]};
            assert (q_dout[c].size() > 0) else begin
              $display("unexpected beat on m_axis_dyn_out channel %0d", c);
              errors++;
            end
            if (q_dout[c].size() > 0) begin
              check_value($sformatf("m_axis_dyn_out[%0d] {tdata,tkeep,tlast}", c),
                          128'(got), 128'(q_dout[c].pop_front()));
            end
          end
          if (m_axis_dyn_in_tvalid[c] && m_axis_dyn_in_tready[c]) begin
            got = {m_axis_dyn_in_tdata[c], m_axis_dyn_in_tkeep[c], m_axis_dyn_in_tlast[c]};
            assert (q_din[c].size() > 0) else begin
              $display("unexpected beat on m_axis_dyn_in channel %0d", c);
              errors++;
            end
            if (q_din[c].size() > 0) begin
              check_value($sformatf("m_axis_dyn_in[%0d] {tdata,tkeep,tlast}", c),
                          128'(got), 128'(q_din[c].pop_front()));
            end
          end
        end
        if (m_axis_wb_tvalid && m_axis_wb_tready) begin
          assert (q_wb.size() > 0) else begin
            $display("unexpected beat on m_axis_wb");
            errors++;
          end
          if (q_wb.size() > 0) begin
            check_value("m_axis_wb {tdata,tkeep,tlast}",
                        128'({m_axis_wb_tdata, m_axis_wb_tkeep, m_axis_wb_tlast}),
                        128'(q_wb.pop_front()));
          end
        end
        if (m_dma_wb_valid && m_dma_wb_ready) begin
          assert (q_req.size() > 0) else begin
            $display("unexpected request on m_dma_wb");
            errors++;
          end
          if (q_req.size() > 0) begin
            check_value("m_dma_wb {addr,len}", 128'({m_dma_wb_addr, m_dma_wb_len}),
                        128'(q_req.pop_front()));
          end
        end
      end
      irq_hist[2] = irq_hist[1];
      irq_hist[1] = irq_hist[0];
      irq_hist[0] = s_usr_irq;
      for (int i = 4; i > 0; i--) begin
        dec_hist[i] = dec_hist[i-1];
      end
      dec_hist[0] = s_decouple;
    end
  endtask

  initial begin
    dcpl_pkg::wback_t rec;
    void'($urandom(32'hf4607de9));
    aresetn               = 1'b0;
    s_decouple            = 1'b0;
    s_usr_irq             = '0;
    s_axis_dyn_out_tdata  = '0;
    s_axis_dyn_out_tkeep  = '0;
    s_axis_dyn_out_tlast  = '0;
    s_axis_dyn_out_tvalid = '0;
    s_axis_dyn_in_tdata   = '0;
    s_axis_dyn_in_tkeep   = '0;
    s_axis_dyn_in_tlast   = '0;
    s_axis_dyn_in_tvalid  = '0;
    m_axis_dyn_out_tready = '1;
    m_axis_dyn_in_tready  = '1;
    s_wback_valid         = 1'b0;
    s_wback_data          = '0;
    m_axis_wb_tready      = 1'b1;
    m_dma_wb_ready        = 1'b1;
    errors                = 0;
    timeouts              = 0;
    checks                = 0;
    n_tests               = 0;
    err_mark              = 0;
    fork
      drive_stalls();
      drive_irq();
      compare_outputs();
    join_none
    repeat (16) @(negedge aclk);
    aresetn = 1'b1;
    repeat (2) @(negedge aclk);

    fork  // all four channels at once.
      stream_burst(1'b0, 0, 40);
      stream_burst(1'b0, 1, 40);
      stream_burst(1'b1, 0, 40);
      stream_burst(1'b1, 1, 40);
    join
    wait_idle("stream pass-through");
    end_test("stream pass-through");

    @(negedge aclk);
    s_decouple = 1'b1;
    repeat (3) @(negedge aclk);  // chain tail is high now.
    s_axis_dyn_out_tvalid = '1;  // user keeps offering.
    fork
      stream_burst(1'b1, 0, 5);  // fits in the six stage slots.
      stream_burst(1'b1, 1, 5);
      watch_cut(24);
    join
    @(negedge aclk);
    s_axis_dyn_out_tvalid = '0;
    s_decouple            = 1'b0;
    wait_idle("stream release");
    end_test("stream decoupling");

    for (int i = 0; i < 80; i++) begin
      @(negedge aclk);
      if ($urandom % 6 == 0) begin
        s_decouple = ~s_decouple;
      end
    end
    @(negedge aclk);
    s_decouple = 1'b0;
    repeat (6) @(negedge aclk);
    end_test("interrupt latency");

    wb_burst(30);
    wait_idle("writeback conversion");
    end_test("writeback conversion");

    @(negedge aclk);
    s_decouple = 1'b1;
    repeat (3) @(negedge aclk);
    rec           = {$urandom, $urandom, $urandom};
    s_wback_data  = rec;
    s_wback_valid = 1'b1;
    watch_cut(12);
    @(negedge aclk);
    s_decouple = 1'b0;
    wait_wb_accept(rec);  // taken once the gate opens.
    @(negedge aclk);
    s_wback_valid = 1'b0;
    wait_idle("writeback release");
    end_test("writeback decoupling");

    $display("%0d tests, %0d checks, %0d errors, %0d timeouts",
             n_tests, checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* hw/axis_dcpl_slice.sv */
`timescale 1ns/1ps

module axis_dcpl_slice #(
  parameter int N_STAGES       = 3,
  parameter bit USER_IS_SOURCE = 1'b0  // 1: gate at input, 0: gate at output.
) (
  input  logic   aclk,
  input  logic   aresetn,
  input  logic   decouple,
  axis_if.slave  s_axis,
  axis_if.master m_axis
);

  localparam int DW = $bits(s_axis.tdata);
  localparam int KW = $bits(s_axis.tkeep);
  localparam int PW = DW + KW + 1;  // data, keep, last.

  logic              gate_in;   // user drives the input side.
  logic              gate_out;  // user sinks the output side.
  logic [N_STAGES:0] vld;       // valid into stage i, index N_STAGES is the output.
  logic [N_STAGES:0] rdy;
  logic [PW-1:0]     pld [N_STAGES+1];

  assign gate_in  = USER_IS_SOURCE ? decouple : 1'b0;
  assign gate_out = USER_IS_SOURCE ? 1'b0 : decouple;

  // input side gate
  assign vld[0]        = s_axis.tvalid & ~gate_in;
  assign s_axis.tready = rdy[0] & ~gate_in;  // user sees no ready while cut.
  assign pld[0]        = {s_axis.tdata, s_axis.tkeep, s_axis.tlast};

  // two-entry skid buffers, ready only looks at own skid slot
  for (genvar i = 0; i < N_STAGES; i++) begin : g_stage
    logic          main_vld;
    logic          skid_vld;
    logic [PW-1:0] main_q;
    logic [PW-1:0] skid_q;

    assign rdy[i]     = ~skid_vld;
    assign vld[i+1]   = main_vld;
    assign pld[i+1]   = main_q;

    always_ff @(posedge aclk) begin
      if (!aresetn) begin
        main_vld <= 1'b0;
        skid_vld <= 1'b0;
      end else if (rdy[i+1] || !main_vld) begin
        main_vld <= skid_vld | vld[i];  // skid drains first, keeps order.
        skid_vld <= 1'b0;
      end else if (vld[i] && !skid_vld) begin
        skid_vld <= 1'b1;  // main stalled, park beat.
      end
    end

    always_ff @(posedge aclk) begin
      if (rdy[i+1] || !main_vld) begin
        main_q <= skid_vld ? skid_q : pld[i];
      end else if (!skid_vld) begin
        skid_q <= pld[i];
      end
    end
  end

  // output side gate
  assign rdy[N_STAGES] = m_axis.tready & ~gate_out;
  assign m_axis.tvalid = vld[N_STAGES] & ~gate_out;  // beats hold in stages while cut.
  assign {m_axis.tdata, m_axis.tkeep, m_axis.tlast} = pld[N_STAGES];

endmodule

/* hw/axis_if.sv */
`timescale 1ns/1ps

interface axis_if #(
  parameter int DATA_BITS = dcpl_pkg::AXI_DATA_BITS
);

  logic [DATA_BITS-1:0]   tdata;
  logic [DATA_BITS/8-1:0] tkeep;  // byte enables.
  logic                   tlast;
  logic                   tvalid;
  logic                   tready;

  modport master (
    output tdata, tkeep, tlast, tvalid,
    input  tready
  );

  modport slave (
    input  tdata, tkeep, tlast, tvalid,
    output tready
  );

  modport monitor (
    input tdata, tkeep, tlast, tvalid, tready
  );

endinterface

/* hw/dcpl_ctrl.sv */
`timescale 1ns/1ps

module dcpl_ctrl (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  logic                          decouple_in,
  input  logic [dcpl_pkg::IRQ_BITS-1:0] usr_irq_in,
  output logic                          decouple,
  output logic [dcpl_pkg::IRQ_BITS-1:0] usr_irq_out
);

  logic [dcpl_pkg::N_REG_STA_DCPL-1:1] dcpl_q;   // registered chain bits.
  logic [dcpl_pkg::N_REG_STA_DCPL-1:0] dcpl_ch;  // full chain, raw request at 0.
  logic [dcpl_pkg::IRQ_BITS-1:0]       irq_gated;
  logic [dcpl_pkg::IRQ_BITS-1:0]       irq_q [dcpl_pkg::N_STAGES_0];

  assign dcpl_ch  = {dcpl_q, decouple_in};
  assign decouple = dcpl_ch[dcpl_pkg::N_REG_STA_DCPL-1];  // last bit gates everything.

  // shift the request along, one bit per cycle
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      dcpl_q <= '0;
    end else begin
      dcpl_q <= dcpl_ch[dcpl_pkg::N_REG_STA_DCPL-2:0];
    end
  end

  assign irq_gated = usr_irq_in & ~{dcpl_pkg::IRQ_BITS{decouple}};  // masked before stages.

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      for (int i = 0; i < dcpl_pkg::N_STAGES_0; i++) begin
        irq_q[i] <= '0;
      end
    end else begin
      irq_q[0] <= irq_gated;
      for (int i = 1; i < dcpl_pkg::N_STAGES_0; i++) begin
        irq_q[i] <= irq_q[i-1];  // plain delay line.
      end
    end
  end

  assign usr_irq_out = irq_q[dcpl_pkg::N_STAGES_0-1];

endmodule

/* hw/dcpl_pkg.sv */
package dcpl_pkg;

  // channel counts and pipeline depths
  localparam int N_SCHAN        = 2;   // stream channels per direction.
  localparam int N_REG_STA_DCPL = 3;   // decouple chain, bit 0 is the raw request.
  localparam int N_STAGES_0     = 3;   // slice depth on irq, stream and wb beat.

  // data widths
  localparam int AXI_DATA_BITS  = 64;  // dynamic stream and wb output bus.
  localparam int WB_DATA_BITS   = 32;  // writeback value and internal beat.
  localparam int IRQ_BITS       = 15;  // user interrupt vector.
  localparam int DMA_ADDR_BITS  = 64;  // host byte address.
  localparam int DMA_LEN_BITS   = 28;  // request length in bytes.

  localparam int WB_LEN         = 4;   // bytes per writeback request.

  // one writeback record from the user region
  typedef struct packed {
    logic [DMA_ADDR_BITS-1:0] paddr;   // host byte address.
    logic [WB_DATA_BITS-1:0]  value;   // word to be written.
  } wback_t;

endpackage

/* hw/dcpl_static.sv */
`timescale 1ns/1ps

module dcpl_static (
  input  logic                                                 aclk,
  input  logic                                                 aresetn,
  input  logic                                                 s_decouple,

  input  logic [dcpl_pkg::IRQ_BITS-1:0]                        s_usr_irq,
  output logic [dcpl_pkg::IRQ_BITS-1:0]                        m_usr_irq,

  input  logic [dcpl_pkg::N_SCHAN-1:0][dcpl_pkg::AXI_DATA_BITS-1:0]   s_axis_dyn_out_tdata,
  input  logic [dcpl_pkg::N_SCHAN-1:0][dcpl_pkg::AXI_DATA_BITS/8-1:0] s_axis_dyn_out_tkeep,
  input  logic [dcpl_pkg::N_SCHAN-1:0]                         s_axis_dyn_out_tlast,
  input  logic [dcpl_pkg::N_SCHAN-1:0]                         s_axis_dyn_out_tvalid,
  output logic [dcpl_pkg::N_SCHAN-1:0]                         s_axis_dyn_out_tready,
  output logic [dcpl_pkg::N_SCHAN-1:0][dcpl_pkg::AXI_DATA_BITS-1:0]   m_axis_dyn_in_tdata,
  output logic [dcpl_pkg::N_SCHAN-1:0][dcpl_pkg::AXI_DATA_BITS/8-1:0] m_axis_dyn_in_tkeep,
  output logic [dcpl_pkg::N_SCHAN-1:0]                         m_axis_dyn_in_tlast,
  output logic [dcpl_pkg::N_SCHAN-1:0]                         m_axis_dyn_in_tvalid,
  input  logic [dcpl_pkg::N_SCHAN-1:0]                         m_axis_dyn_in_tready,

  input  logic [dcpl_pkg::N_SCHAN-1:0][dcpl_pkg::AXI_DATA_BITS-1:0]   s_axis_dyn_in_tdata,
  input  logic [dcpl_pkg::N_SCHAN-1:0][dcpl_pkg::AXI_DATA_BITS/8-1:0] s_axis_dyn_in_tkeep,
  input  logic [dcpl_pkg::N_SCHAN-1:0]                         s_axis_dyn_in_tlast,
  input  logic [dcpl_pkg::N_SCHAN-1:0]                         s_axis_dyn_in_tvalid,
  output logic [dcpl_pkg::N_SCHAN-1:0]                         s_axis_dyn_in_tready,
  output logic [dcpl_pkg::N_SCHAN-1:0][dcpl_pkg::AXI_DATA_BITS-1:0]   m_axis_dyn_out_tdata,
  output logic [dcpl_pkg::N_SCHAN-1:0][dcpl_pkg::AXI_DATA_BITS/8-1:0] m_axis_dyn_out_tkeep,
  output logic [dcpl_pkg::N_SCHAN-1:0]                         m_axis_dyn_out_tlast,
  output logic [dcpl_pkg::N_SCHAN-1:0]                         m_axis_dyn_out_tvalid,
  input  logic [dcpl_pkg::N_SCHAN-1:0]                         m_axis_dyn_out_tready,

  input  logic                                                 s_wback_valid,
  output logic                                                 s_wback_ready,
  input  dcpl_pkg::wback_t                                     s_wback_data,
  output logic [dcpl_pkg::AXI_DATA_BITS-1:0]                   m_axis_wb_tdata,
  output logic [dcpl_pkg::AXI_DATA_BITS/8-1:0]                 m_axis_wb_tkeep,
  output logic                                                 m_axis_wb_tlast,
  output logic                                                 m_axis_wb_tvalid,
  input  logic                                                 m_axis_wb_tready,

  output logic [dcpl_pkg::DMA_ADDR_BITS-1:0]                   m_dma_wb_addr,
  output logic [dcpl_pkg::DMA_LEN_BITS-1:0]                    m_dma_wb_len,
  output logic                                                 m_dma_wb_valid,
  input  logic                                                 m_dma_wb_ready
);

  localparam int PAD_BITS = dcpl_pkg::AXI_DATA_BITS - dcpl_pkg::WB_DATA_BITS;

  logic decouple;       // chain tail, 2 cycles behind s_decouple.
  logic wb_valid_gated;
  logic wb_ready;

  axis_if #(.DATA_BITS(dcpl_pkg::WB_DATA_BITS)) axis_wb ();
  axis_if #(.DATA_BITS(dcpl_pkg::WB_DATA_BITS)) axis_wb_out ();
  dma_req_if dma_wb ();

  dcpl_ctrl u_ctrl (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .decouple_in (s_decouple),
    .usr_irq_in  (s_usr_irq),
    .decouple    (decouple),
    .usr_irq_out (m_usr_irq)
  );

  for (genvar i = 0; i < dcpl_pkg::N_SCHAN; i++) begin : g_chan
    axis_if #(.DATA_BITS(dcpl_pkg::AXI_DATA_BITS)) dout_s ();
    axis_if #(.DATA_BITS(dcpl_pkg::AXI_DATA_BITS)) dout_m ();
    axis_if #(.DATA_BITS(dcpl_pkg::AXI_DATA_BITS)) din_s ();
    axis_if #(.DATA_BITS(dcpl_pkg::AXI_DATA_BITS)) din_m ();

    // user to static, cut at input.
    assign dout_s.tdata             = s_axis_dyn_out_tdata[i];
    assign dout_s.tkeep             = s_axis_dyn_out_tkeep[i];
    assign dout_s.tlast             = s_axis_dyn_out_tlast[i];
    assign dout_s.tvalid            = s_axis_dyn_out_tvalid[i];
    assign s_axis_dyn_out_tready[i] = dout_s.tready;
    assign m_axis_dyn_out_tdata[i]  = dout_m.tdata;
    assign m_axis_dyn_out_tkeep[i]  = dout_m.tkeep;
    assign m_axis_dyn_out_tlast[i]  = dout_m.tlast;
    assign m_axis_dyn_out_tvalid[i] = dout_m.tvalid;
    assign dout_m.tready            = m_axis_dyn_out_tready[i];

    axis_dcpl_slice #(.N_STAGES(dcpl_pkg::N_STAGES_0), .USER_IS_SOURCE(1'b1)) u_dyn_out (
      .aclk     (aclk),
      .aresetn  (aresetn),
      .decouple (decouple),
      .s_axis   (dout_s),
      .m_axis   (dout_m)
    );

    // static to user, cut at output.
    assign din_s.tdata             = s_axis_dyn_in_tdata[i];
    assign din_s.tkeep             = s_axis_dyn_in_tkeep[i];
    assign din_s.tlast             = s_axis_dyn_in_tlast[i];
    assign din_s.tvalid            = s_axis_dyn_in_tvalid[i];
    assign s_axis_dyn_in_tready[i] = din_s.tready;
    assign m_axis_dyn_in_tdata[i]  = din_m.tdata;
    assign m_axis_dyn_in_tkeep[i]  = din_m.tkeep;
    assign m_axis_dyn_in_tlast[i]  = din_m.tlast;
    assign m_axis_dyn_in_tvalid[i] = din_m.tvalid;
    assign din_m.tready            = m_axis_dyn_in_tready[i];

    axis_dcpl_slice #(.N_STAGES(dcpl_pkg::N_STAGES_0), .USER_IS_SOURCE(1'b0)) u_dyn_in (
      .aclk     (aclk),
      .aresetn  (aresetn),
      .decouple (decouple),
      .s_axis   (din_s),
      .m_axis   (din_m)
    );
  end

  // writeback input gate
  assign wb_valid_gated = s_wback_valid & ~decouple;
  assign s_wback_ready  = wb_ready & ~decouple;

  wback_dma u_wback (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .wback_valid  (wb_valid_gated),
    .wback_ready  (wb_ready),
    .wback_data   (s_wback_data),
    .m_dma_wr     (dma_wb),
    .m_axis_wback (axis_wb)
  );

  assign m_dma_wb_addr  = dma_wb.addr;
  assign m_dma_wb_len   = dma_wb.len;
  assign m_dma_wb_valid = dma_wb.valid;
  assign dma_wb.ready   = m_dma_wb_ready;

  // beat is already static side, no cut here.
  axis_dcpl_slice #(.N_STAGES(dcpl_pkg::N_STAGES_0), .USER_IS_SOURCE(1'b0)) u_wb_beat (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .decouple (1'b0),
    .s_axis   (axis_wb),
    .m_axis   (axis_wb_out)
  );

  // widen onto the 64-bit bus, upper lanes zero.
  assign m_axis_wb_tdata    = {{PAD_BITS{1'b0}}, axis_wb_out.tdata};
  assign m_axis_wb_tkeep    = {{(PAD_BITS/8){1'b0}}, axis_wb_out.tkeep};
  assign m_axis_wb_tlast    = axis_wb_out.tlast;
  assign m_axis_wb_tvalid   = axis_wb_out.tvalid;
  assign axis_wb_out.tready = m_axis_wb_tready;

endmodule

/* hw/dma_req_if.sv */
`timescale 1ns/1ps

interface dma_req_if;

  logic [dcpl_pkg::DMA_ADDR_BITS-1:0] addr;  // host byte address.
  logic [dcpl_pkg::DMA_LEN_BITS-1:0]  len;   // length in bytes.
  logic                               valid;
  logic                               ready;

  modport master (
    output addr, len, valid,
    input  ready
  );

  modport slave (
    input  addr, len, valid,
    output ready
  );

endinterface

/* hw/wback_dma.sv */
`timescale 1ns/1ps

module wback_dma (
  input  logic             aclk,
  input  logic             aresetn,
  input  logic             wback_valid,
  output logic             wback_ready,
  input  dcpl_pkg::wback_t wback_data,
  dma_req_if.master        m_dma_wr,
  axis_if.master           m_axis_wback
);

  logic             req_pend;   // dma request not yet taken.
  logic             beat_pend;  // stream beat not yet taken.
  dcpl_pkg::wback_t wb_q;       // record held for both outputs.
  logic             wb_acc;
  logic             req_done;
  logic             beat_done;

  assign wback_ready = ~req_pend & ~beat_pend;  // idle only when both drained.
  assign wb_acc      = wback_valid & wback_ready;
  assign req_done    = m_dma_wr.valid & m_dma_wr.ready;
  assign beat_done   = m_axis_wback.tvalid & m_axis_wback.tready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      req_pend  <= 1'b0;
      beat_pend <= 1'b0;
    end else if (wb_acc) begin
      req_pend  <= 1'b1;
      beat_pend <= 1'b1;
    end else begin
      if (req_done) begin
        req_pend <= 1'b0;
      end
      if (beat_done) begin
        beat_pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (wb_acc) begin
      wb_q <= wback_data;
    end
  end

  // write request, fixed length
  assign m_dma_wr.addr  = wb_q.paddr;
  assign m_dma_wr.len   = dcpl_pkg::DMA_LEN_BITS'(dcpl_pkg::WB_LEN);
  assign m_dma_wr.valid = req_pend;

  // single-beat packet with the value
  assign m_axis_wback.tdata  = wb_q.value;
  assign m_axis_wback.tkeep  = '1;
  assign m_axis_wback.tlast  = 1'b1;
  assign m_axis_wback.tvalid = beat_pend;

endmodule

/* tb.f */
hw/dcpl_pkg.sv
hw/axis_if.sv
hw/dma_req_if.sv
hw/dcpl_ctrl.sv
hw/axis_dcpl_slice.sv
hw/wback_dma.sv
hw/dcpl_static.sv
bench/tb_dcpl_static.sv
